/* common/fdc_host_pkg.sv */
`default_nettype none

package fdc_host_pkg;

	// ------------------------------------------------------------------------
	// host register map
	// ------------------------------------------------------------------------

	// command and status share address 0
	typedef enum logic [2:0] {
		REG_CMD    = 3'd0,
		REG_TRACK  = 3'd1,
		REG_SECTOR = 3'd2,
		REG_DATA   = 3'd3,
		REG_CTRL   = 3'd7
	} reg_addr_e;

	// command high nibble
	// odd step codes also update the track register
	typedef enum logic [3:0] {
		OP_RESTORE    = 4'h0,
		OP_SEEK       = 4'h1,
		OP_STEP       = 4'h2,
		OP_STEP_U     = 4'h3,
		OP_STEP_IN    = 4'h4,
		OP_STEP_IN_U  = 4'h5,
		OP_STEP_OUT   = 4'h6,
		OP_STEP_OUT_U = 4'h7,
		OP_READ       = 4'h8,
		OP_READ_M     = 4'h9,
		OP_WRITE      = 4'hA,
		OP_WRITE_M    = 4'hB,
		OP_INTERRUPT  = 4'hD
	} fdc_opcode_e;

	// one host bus cycle
	typedef struct packed {
		logic       rd;
		logic       wr;
		reg_addr_e  addr;
		logic [7:0] wdata;
	} host_bus_t;

	// status byte, msb first
	// bits 5, 2 and 1 depend on the command type
	typedef struct packed {
		logic not_ready;
		logic write_protect;
		logic head_or_fault;
		logic seek_error;
		logic crc_error;
		logic track0_or_lost;
		logic index_or_drq;
		logic busy;
	} fdc_status_t;

endpackage

`default_nettype wire

/* common/fdc_cpu_pkg.sv */
`default_nettype none

package fdc_cpu_pkg;

	// ------------------------------------------------------------------------
	// workhorse request / status protocol
	// ------------------------------------------------------------------------

	// request high nibble, argument goes in the low nibble
	typedef enum logic [3:0] {
		REQ_READ  = 4'h1,
		REQ_WRITE = 4'h2,
		REQ_NOP   = 4'h4,
		REQ_ACK   = 4'h8
	} cpu_request_e;

	// status byte returned by the workhorse
	typedef struct packed {
		logic [3:0] reserved;
		logic       no_image;
		logic       crc;
		logic       success;
		logic       done;
	} cpu_status_t;

	// ------------------------------------------------------------------------
	// sequencer to datapath
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic busy;
		logic drq;
		logic seek_error;
		logic crc_error;
		logic write_fault;
	} seq_flags_t;

	typedef enum logic [1:0] {
		HEAD_NONE,
		HEAD_RESTORE,
		HEAD_SEEK,
		HEAD_STEP
	} head_action_e;

	typedef struct packed {
		logic         accept;
		head_action_e head;
		logic         load_data;
		logic         clear_pending;
	} seq_ctrl_t;

	// sector buffer port
	typedef struct packed {
		logic [9:0] addr;
		logic       rd;
		logic       wr;
		logic [7:0] wdata;
	} buffer_port_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_WAIT_NOP,
		S_WAIT_READ,
		S_READ_START,
		S_READ_PACE,
		S_READ_DRQ,
		S_READ_ADVANCE,
		S_WRITE_DRQ,
		S_WRITE_STROBE,
		S_WRITE_NEXT,
		S_WAIT_WRITE,
		S_ABORT,
		S_END_ACK,
		S_END_WAIT
	} seq_state_e;

endpackage

`default_nettype wire

/* source/fdc_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_registers (
	input  wire                           clk,
	input  wire                           reset_n,
	input  wire fdc_host_pkg::host_bus_t  host,
	input  wire fdc_cpu_pkg::seq_ctrl_t   ctrl,
	input  wire fdc_cpu_pkg::seq_flags_t  flags,
	input  wire fdc_cpu_pkg::cpu_status_t cpu_status,
	input  wire [7:0]                     buff_rdata,
	output logic [7:0]                    odata,
	output logic [7:0]                    command,
	output logic                          pending,
	output logic                          side,
	output logic                          drive,
	output logic [7:0]                    track_out,
	output logic [7:0]                    sector_out,
	output fdc_host_pkg::fdc_status_t     status_out,
	output logic [7:0]                    buff_wdata
);

	logic [7:0] track_reg;
	logic [7:0] sector_reg;
	logic [7:0] data_reg;
	logic [7:0] head_track;
	logic       step_out;
	logic       cmd_mode;
	logic       index;
	logic       head_loaded;
	logic       step_dir;
	logic [7:0] next_track;

	fdc_host_pkg::fdc_status_t status;

	// given direction wins, else the last one used
	assign step_dir   = command[6] ? command[5] : step_out;
	assign next_track = step_dir ? head_track - 8'd1 : head_track + 8'd1;

	// ------------------------------------------------------------------------
	// status byte, type I or type II layout
	// ------------------------------------------------------------------------

	always_comb begin
		status.not_ready     = cpu_status.no_image;
		status.write_protect = 1'b0;
		status.seek_error    = flags.seek_error;
		status.crc_error     = flags.crc_error;
		status.busy          = flags.busy | pending;
		if (!cmd_mode) begin
			status.head_or_fault  = head_loaded;
			status.track0_or_lost = (head_track == 8'd0);
			status.index_or_drq   = index;
		end else begin
			// lost data never happens
			status.head_or_fault  = flags.write_fault;
			status.track0_or_lost = 1'b0;
			status.index_or_drq   = flags.drq;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			odata       <= '0;
			track_reg   <= '0;
			sector_reg  <= '0;
			data_reg    <= '0;
			command     <= '0;
			pending     <= 1'b0;
			side        <= 1'b0;
			drive       <= 1'b0;
			head_track  <= 8'hff;
			step_out    <= 1'b0;
			cmd_mode    <= 1'b0;
			index       <= 1'b0;
			head_loaded <= 1'b0;
		end else begin
			// host reads, odata one cycle after rd
			if (host.rd) begin
				case (host.addr)
					fdc_host_pkg::REG_CMD: begin
						odata <= status;
						index <= 1'b0;
					end
					fdc_host_pkg::REG_TRACK:  odata <= track_reg;
					fdc_host_pkg::REG_SECTOR: odata <= sector_reg;
					fdc_host_pkg::REG_DATA:   odata <= data_reg;
					fdc_host_pkg::REG_CTRL:   odata <= {5'b11111, side, 1'b0, drive};
					default: ;
				endcase
			end

			// host writes
			if (host.wr) begin
				case (host.addr)
					fdc_host_pkg::REG_CMD: begin
						// interrupt goes straight to the sequencer
						if (host.wdata[7:4] != fdc_host_pkg::OP_INTERRUPT) begin
							command <= host.wdata;
							pending <= 1'b1;
						end
					end
					fdc_host_pkg::REG_TRACK:
						if (!flags.busy)
							track_reg <= host.wdata;
					fdc_host_pkg::REG_SECTOR:
						if (!flags.busy)
							sector_reg <= host.wdata;
					fdc_host_pkg::REG_DATA:   data_reg <= host.wdata;
					fdc_host_pkg::REG_CTRL: begin
						side  <= host.wdata[2];
						drive <= host.wdata[0];
					end
					default: ;
				endcase
			end

			// byte from the sector buffer
			if (ctrl.load_data)
				data_reg <= buff_rdata;

			if (ctrl.accept) begin
				pending  <= 1'b0;
				cmd_mode <= command[7];
			end
			if (ctrl.clear_pending)
				pending <= 1'b0;

			// head movement for type I
			if (ctrl.head != fdc_cpu_pkg::HEAD_NONE) begin
				head_loaded <= command[3];
				index       <= 1'b1;
			end
			case (ctrl.head)
				fdc_cpu_pkg::HEAD_RESTORE: begin
					track_reg  <= 8'd0;
					head_track <= 8'd0;
				end
				fdc_cpu_pkg::HEAD_SEEK:
					head_track <= data_reg;
				fdc_cpu_pkg::HEAD_STEP: begin
					step_out   <= step_dir;
					head_track <= next_track;
					if (command[4])
						track_reg <= next_track;
				end
				default: ;
			endcase
		end
	end

	// workhorse sees the real head position
	assign track_out  = head_track;
	assign sector_out = sector_reg;
	assign status_out = status;
	assign buff_wdata = data_reg;

endmodule

`default_nettype wire

/* sequencer/fdc_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_sequencer (
	input  wire                           clk,
	input  wire                           reset_n,
	input  wire fdc_host_pkg::host_bus_t  host,
	input  wire [7:0]                     command,
	input  wire                           pending,
	input  wire                           side,
	input  wire                           drive,
	input  wire fdc_cpu_pkg::cpu_status_t cpu_status,
	input  wire                           last_byte,
	input  wire                           pace_done,
	output fdc_cpu_pkg::seq_ctrl_t        ctrl,
	output fdc_cpu_pkg::seq_flags_t       flags,
	output logic [7:0]                    cpu_request,
	output logic                          buff_rd,
	output logic                          buff_wr,
	output logic                          count_load,
	output logic                          count_advance,
	output logic                          pace_start
);

	fdc_cpu_pkg::seq_state_e   state;
	fdc_host_pkg::fdc_opcode_e opcode;
	fdc_cpu_pkg::head_action_e head_action;

	logic is_type1;
	logic is_read;
	logic is_write;
	logic accept;
	logic abort_req;
	logic data_rd;
	logic data_wr;
	logic cpu_ok;
	logic cpu_fail;

	// ------------------------------------------------------------------------
	// opcode decode
	// ------------------------------------------------------------------------

	assign opcode = fdc_host_pkg::fdc_opcode_e'(command[7:4]);

	always_comb begin
		head_action = fdc_cpu_pkg::HEAD_NONE;
		is_read     = 1'b0;
		is_write    = 1'b0;
		case (opcode)
			fdc_host_pkg::OP_RESTORE: head_action = fdc_cpu_pkg::HEAD_RESTORE;
			fdc_host_pkg::OP_SEEK:    head_action = fdc_cpu_pkg::HEAD_SEEK;
			fdc_host_pkg::OP_STEP, fdc_host_pkg::OP_STEP_U,
			fdc_host_pkg::OP_STEP_IN, fdc_host_pkg::OP_STEP_IN_U,
			fdc_host_pkg::OP_STEP_OUT, fdc_host_pkg::OP_STEP_OUT_U:
				head_action = fdc_cpu_pkg::HEAD_STEP;
			fdc_host_pkg::OP_READ, fdc_host_pkg::OP_READ_M:   is_read = 1'b1;
			fdc_host_pkg::OP_WRITE, fdc_host_pkg::OP_WRITE_M: is_write = 1'b1;
			// read address and track ops are not emulated
			default: ;
		endcase
	end

	assign is_type1 = (head_action != fdc_cpu_pkg::HEAD_NONE);

	// host strobes of interest
	assign abort_req = host.wr && host.addr == fdc_host_pkg::REG_CMD &&
		host.wdata[7:4] == fdc_host_pkg::OP_INTERRUPT;
	assign data_rd = host.rd && host.addr == fdc_host_pkg::REG_DATA;
	assign data_wr = host.wr && host.addr == fdc_host_pkg::REG_DATA;

	// workhorse verdict, no image counts as failure
	assign cpu_ok   = cpu_status.done && cpu_status.success && !cpu_status.no_image;
	assign cpu_fail = cpu_status.no_image || (cpu_status.done && !cpu_status.success);

	// ------------------------------------------------------------------------
	// orders to registers and counter
	// ------------------------------------------------------------------------

	// pending seen in idle starts the command
	assign accept = (state == fdc_cpu_pkg::S_IDLE) && pending;

	always_comb begin
		ctrl.accept        = accept;
		ctrl.head          = accept ? head_action : fdc_cpu_pkg::HEAD_NONE;
		ctrl.load_data     = (state == fdc_cpu_pkg::S_READ_PACE) && pace_done;
		ctrl.clear_pending = (state == fdc_cpu_pkg::S_ABORT);
	end

	// buffer address restarts on read success or write start
	assign count_load = (state == fdc_cpu_pkg::S_WAIT_READ && cpu_ok) ||
		(accept && is_write);
	assign count_advance = (state == fdc_cpu_pkg::S_READ_ADVANCE) ||
		(state == fdc_cpu_pkg::S_WRITE_NEXT);
	assign pace_start = (state == fdc_cpu_pkg::S_READ_START);

	// ------------------------------------------------------------------------
	// command FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state       <= fdc_cpu_pkg::S_IDLE;
			flags       <= '0;
			cpu_request <= {fdc_cpu_pkg::REQ_ACK, 4'h0};
			buff_rd     <= 1'b0;
			buff_wr     <= 1'b0;
		end else begin
			// write strobe lasts one cycle
			buff_wr <= 1'b0;

			case (state)
				fdc_cpu_pkg::S_IDLE: begin
					if (pending) begin
						if (is_type1) begin
							flags.busy  <= 1'b1;
							cpu_request <= {fdc_cpu_pkg::REQ_NOP, command[7:4]};
							state       <= fdc_cpu_pkg::S_WAIT_NOP;
						end else if (is_read) begin
							flags       <= '0;
							flags.busy  <= 1'b1;
							cpu_request <= {fdc_cpu_pkg::REQ_READ, 2'b00, drive, side};
							state       <= fdc_cpu_pkg::S_WAIT_READ;
						end else if (is_write) begin
							flags      <= '0;
							flags.busy <= 1'b1;
							flags.drq  <= 1'b1;
							state      <= fdc_cpu_pkg::S_WRITE_DRQ;
						end
					end
				end

				// type I, the workhorse only has to notice
				fdc_cpu_pkg::S_WAIT_NOP: begin
					if (cpu_status.done)
						state <= fdc_cpu_pkg::S_END_ACK;
				end

				// sector read, buffer to host
				fdc_cpu_pkg::S_WAIT_READ: begin
					if (cpu_fail) begin
						flags.seek_error <= 1'b1;
						flags.crc_error  <= cpu_status.crc;
						state            <= fdc_cpu_pkg::S_END_ACK;
					end else if (cpu_ok) begin
						buff_rd <= 1'b1;
						state   <= fdc_cpu_pkg::S_READ_START;
					end
				end
				fdc_cpu_pkg::S_READ_START:
					state <= fdc_cpu_pkg::S_READ_PACE;
				fdc_cpu_pkg::S_READ_PACE: begin
					// data register takes the byte in the same cycle
					if (pace_done) begin
						flags.drq <= 1'b1;
						state     <= fdc_cpu_pkg::S_READ_DRQ;
					end
				end
				fdc_cpu_pkg::S_READ_DRQ: begin
					// slow host just keeps drq up
					if (data_rd) begin
						flags.drq <= 1'b0;
						if (last_byte) begin
							buff_rd <= 1'b0;
							state   <= fdc_cpu_pkg::S_END_ACK;
						end else begin
							state <= fdc_cpu_pkg::S_READ_ADVANCE;
						end
					end
				end
				fdc_cpu_pkg::S_READ_ADVANCE:
					state <= fdc_cpu_pkg::S_READ_START;

				// sector write, host to buffer
				fdc_cpu_pkg::S_WRITE_DRQ: begin
					if (data_wr) begin
						flags.drq <= 1'b0;
						state     <= fdc_cpu_pkg::S_WRITE_STROBE;
					end
				end
				fdc_cpu_pkg::S_WRITE_STROBE: begin
					buff_wr <= 1'b1;
					state   <= fdc_cpu_pkg::S_WRITE_NEXT;
				end
				fdc_cpu_pkg::S_WRITE_NEXT: begin
					if (last_byte) begin
						// whole sector buffered, hand it over
						cpu_request <= {fdc_cpu_pkg::REQ_WRITE, 3'b000, side};
						state       <= fdc_cpu_pkg::S_WAIT_WRITE;
					end else begin
						flags.drq <= 1'b1;
						state     <= fdc_cpu_pkg::S_WRITE_DRQ;
					end
				end
				fdc_cpu_pkg::S_WAIT_WRITE: begin
					if (cpu_fail) begin
						flags.write_fault <= cpu_status.crc;
						state             <= fdc_cpu_pkg::S_END_ACK;
					end else if (cpu_ok) begin
						state <= fdc_cpu_pkg::S_END_ACK;
					end
				end

				// interrupt, drop the transfer
				fdc_cpu_pkg::S_ABORT: begin
					flags.drq         <= 1'b0;
					flags.seek_error  <= 1'b0;
					flags.crc_error   <= 1'b0;
					flags.write_fault <= 1'b0;
					buff_rd           <= 1'b0;
					state             <= fdc_cpu_pkg::S_END_ACK;
				end

				// end exchange, every command passes here
				fdc_cpu_pkg::S_END_ACK: begin
					cpu_request <= {fdc_cpu_pkg::REQ_ACK, 4'h0};
					state       <= fdc_cpu_pkg::S_END_WAIT;
				end
				fdc_cpu_pkg::S_END_WAIT: begin
					if (cpu_status == '0) begin
						cpu_request <= 8'h00;
						flags.busy  <= 1'b0;
						flags.drq   <= 1'b0;
						state       <= fdc_cpu_pkg::S_IDLE;
					end
				end

				default: state <= fdc_cpu_pkg::S_IDLE;
			endcase

			// nibble D overrides whatever is running
			if (abort_req && state != fdc_cpu_pkg::S_IDLE)
				state <= fdc_cpu_pkg::S_ABORT;
		end
	end

endmodule

`default_nettype wire

/* source/fdc_transfer_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_transfer_counter #(
	parameter int SECTOR_SIZE = 1024,
	parameter int PACE_CYCLES = 15
) (
	input  wire        clk,
	input  wire        reset_n,
	input  wire        load,
	input  wire        advance,
	input  wire        pace_start,
	output logic [9:0] addr,
	output logic       last_byte,
	output logic       pace_done
);

	localparam int CW = $clog2(SECTOR_SIZE + 1);
	localparam int TW = $clog2(PACE_CYCLES + 1);

	logic [CW-1:0] remaining;
	logic [TW-1:0] pace_timer;

	// ------------------------------------------------------------------------
	// buffer address and byte count
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			addr      <= '0;
			remaining <= '0;
		end else if (load) begin
			addr      <= '0;
			remaining <= CW'(SECTOR_SIZE);
		end else if (advance) begin
			addr      <= addr + 10'd1;
			remaining <= remaining - 1'b1;
		end
	end

	assign last_byte = (remaining == CW'(1));

	// drq pace, zero after PACE_CYCLES cycles
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			pace_timer <= '0;
		else if (pace_start)
			pace_timer <= TW'(PACE_CYCLES - 1);
		else if (pace_timer != '0)
			pace_timer <= pace_timer - 1'b1;
	end

	assign pace_done = (pace_timer == '0);

endmodule

`default_nettype wire

/* source/fdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_top #(
	parameter int SECTOR_SIZE = 1024,
	parameter int PACE_CYCLES = 15
) (
	input  wire                       clk,
	input  wire                       reset_n,
	input  wire fdc_host_pkg::host_bus_t  host,
	output logic [7:0]                odata,
	output fdc_cpu_pkg::buffer_port_t buffer,
	input  wire [7:0]                 buff_rdata,
	output logic [7:0]                track_out,
	output logic [7:0]                sector_out,
	output fdc_host_pkg::fdc_status_t status_out,
	output logic [7:0]                cpu_request,
	input  wire fdc_cpu_pkg::cpu_status_t cpu_status,
	output logic                      irq,
	output logic                      drq
);

	// registers to sequencer
	logic [7:0] command;
	logic       pending;
	logic       side;
	logic       drive;

	// sequencer to datapath
	fdc_cpu_pkg::seq_ctrl_t  ctrl;
	fdc_cpu_pkg::seq_flags_t flags;
	logic                    buff_rd;
	logic                    buff_wr;
	logic [7:0]              buff_wdata;

	// transfer counter handshake
	logic       count_load;
	logic       count_advance;
	logic       pace_start;
	logic       last_byte;
	logic       pace_done;
	logic [9:0] buff_addr;

	fdc_registers u_registers (
		.clk        (clk),
		.reset_n    (reset_n),
		.host       (host),
		.ctrl       (ctrl),
		.flags      (flags),
		.cpu_status (cpu_status),
		.buff_rdata (buff_rdata),
		.odata      (odata),
		.command    (command),
		.pending    (pending),
		.side       (side),
		.drive      (drive),
		.track_out  (track_out),
		.sector_out (sector_out),
		.status_out (status_out),
		.buff_wdata (buff_wdata)
	);

	fdc_sequencer u_sequencer (
		.clk           (clk),
		.reset_n       (reset_n),
		.host          (host),
		.command       (command),
		.pending       (pending),
		.side          (side),
		.drive         (drive),
		.cpu_status    (cpu_status),
		.last_byte     (last_byte),
		.pace_done     (pace_done),
		.ctrl          (ctrl),
		.flags         (flags),
		.cpu_request   (cpu_request),
		.buff_rd       (buff_rd),
		.buff_wr       (buff_wr),
		.count_load    (count_load),
		.count_advance (count_advance),
		.pace_start    (pace_start)
	);

	fdc_transfer_counter #(
		.SECTOR_SIZE (SECTOR_SIZE),
		.PACE_CYCLES (PACE_CYCLES)
	) u_counter (
		.clk        (clk),
		.reset_n    (reset_n),
		.load       (count_load),
		.advance    (count_advance),
		.pace_start (pace_start),
		.addr       (buff_addr),
		.last_byte  (last_byte),
		.pace_done  (pace_done)
	);

	// buffer port gathered from the three blocks
	assign buffer.addr  = buff_addr;
	assign buffer.rd    = buff_rd;
	assign buffer.wr    = buff_wr;
	assign buffer.wdata = buff_wdata;

	assign irq = flags.busy;
	assign drq = flags.drq;

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// free running clock for the testbench
module tb_clock #(
	parameter real PERIOD = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

/* test/fdc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fdc_tb;

	localparam int SECTOR_SIZE = 16;
	localparam int PACE_CYCLES = 15;

	// rough cycle budget of each test
	localparam int LEN_RESET = 16;
	localparam int LEN_REGS  = 8 * 30;
	localparam int LEN_TYPE1 = 16 * 60;
	localparam int LEN_READ  = SECTOR_SIZE * 30 + 80;
	localparam int LEN_WRITE = SECTOR_SIZE * 20 + 80;
	localparam int LEN_FAIL  = 80;
	localparam int LEN_ABORT = 80;
	localparam int LIMIT = (LEN_RESET + LEN_REGS + LEN_TYPE1 + LEN_READ + LEN_WRITE +
		LEN_FAIL + LEN_ABORT) * 4;

	logic                       clk;
	logic                       reset_n;
	fdc_host_pkg::host_bus_t    host;
	logic [7:0]                 odata;
	fdc_cpu_pkg::buffer_port_t  buffer;
	logic [7:0]                 buff_rdata;
	logic [7:0]                 track_out;
	logic [7:0]                 sector_out;
	fdc_host_pkg::fdc_status_t  status_out;
	logic [7:0]                 cpu_request;
	fdc_cpu_pkg::cpu_status_t   cpu_status;
	logic                       irq;
	logic                       drq;

	// buffer memory and reference state
	logic [7:0]  mem [0:1023];
	logic [7:0]  exp_wr [0:1023];
	int          wr_count;
	int          errors;
	int          cycles;
	logic [31:0] stim_seed;
	logic [31:0] cpu_seed;
	logic        fail_read;
	logic        fail_crc;
	logic [7:0]  m_track;
	logic [7:0]  m_sector;
	logic [7:0]  m_head;
	logic [7:0]  m_data;
	logic        m_dir;
	logic        m_side;
	logic        m_drive;

	tb_clock #(.PERIOD(4.0)) u_clock (.clk(clk));

	fdc_top #(
		.SECTOR_SIZE (SECTOR_SIZE),
		.PACE_CYCLES (PACE_CYCLES)
	) u_dut (
		.clk         (clk),
		.reset_n     (reset_n),
		.host        (host),
		.odata       (odata),
		.buffer      (buffer),
		.buff_rdata  (buff_rdata),
		.track_out   (track_out),
		.sector_out  (sector_out),
		.status_out  (status_out),
		.cpu_request (cpu_request),
		.cpu_status  (cpu_status),
		.irq         (irq),
		.drq         (drq)
	);

	// buffer read is combinational
	assign buff_rdata = mem[buffer.addr];

	// ------------------------------------------------------------------------
	// random numbers and compare tasks
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic draw(input int n, inout logic [31:0] s, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], s[0]};
			s = lfsr_next(s);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input fdc_host_pkg::fdc_status_t exp,
		input fdc_host_pkg::fdc_status_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %08b, actual %08b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_request(input string name, input logic [7:0] exp,
		input logic [7:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// host bus cycles
	// ------------------------------------------------------------------------

	task automatic host_write(input fdc_host_pkg::reg_addr_e a, input logic [7:0] d);
		fdc_host_pkg::host_bus_t h;
		h.rd = 1'b0;
		h.wr = 1'b1;
		h.addr = a;
		h.wdata = d;
		@(posedge clk);
		host <= h;
		@(posedge clk);
		host <= '0;
	endtask

	// odata is valid one cycle after rd
	task automatic host_read(input fdc_host_pkg::reg_addr_e a, output logic [7:0] d);
		fdc_host_pkg::host_bus_t h;
		h.rd = 1'b1;
		h.wr = 1'b0;
		h.addr = a;
		h.wdata = '0;
		@(posedge clk);
		host <= h;
		@(posedge clk);
		host <= '0;
		@(negedge clk);
		d = odata;
	endtask

	task automatic wait_busy(input logic level);
		do @(negedge clk); while (irq !== level);
	endtask

	task automatic wait_drq();
		do @(negedge clk); while (drq !== 1'b1);
	endtask

	task automatic wait_request(input logic [3:0] code);
		do @(negedge clk); while (cpu_request[7:4] !== code);
	endtask

	// ------------------------------------------------------------------------
	// workhorse model
	// ------------------------------------------------------------------------

	initial begin
		logic [3:0]               req;
		logic [31:0]              d;
		fdc_cpu_pkg::cpu_status_t st;
		cpu_status = '0;
		forever begin
			@(posedge clk);
			req = cpu_request[7:4];
			if (reset_n && cpu_status == '0 && (req == fdc_cpu_pkg::REQ_READ ||
				req == fdc_cpu_pkg::REQ_WRITE || req == fdc_cpu_pkg::REQ_NOP)) begin
				draw(3, cpu_seed, d);
				repeat (d + 2) @(posedge clk);
				st = '0;
				st.done = 1'b1;
				// failure only on reads that the test arms
				if (req == fdc_cpu_pkg::REQ_READ && fail_read)
					st.crc = fail_crc;
				else
					st.success = 1'b1;
				cpu_status <= st;
				do @(posedge clk); while (cpu_request[7:4] != fdc_cpu_pkg::REQ_ACK);
				draw(3, cpu_seed, d);
				repeat (d + 1) @(posedge clk);
				cpu_status <= '0;
			end
		end
	end

	// buffer writes against the bytes the host sent
	always @(posedge clk) begin
		if (reset_n && buffer.wr) begin
			check_byte("buffer write address", wr_count[7:0], buffer.addr[7:0]);
			check_byte("buffer write data", exp_wr[wr_count], buffer.wdata);
			mem[buffer.addr] <= buffer.wdata;
			wr_count <= wr_count + 1;
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// type I command with reference model
	// ------------------------------------------------------------------------

	task automatic do_type1(input logic [3:0] op);
		logic [31:0]               r;
		logic [7:0]                v;
		logic [7:0]                next;
		logic                      h;
		fdc_host_pkg::fdc_status_t st;
		draw(8, stim_seed, r);
		m_data = r[7:0];
		host_write(fdc_host_pkg::REG_DATA, m_data);
		draw(1, stim_seed, r);
		h = r[0];
		host_write(fdc_host_pkg::REG_CMD, {op, h, 3'b000});
		wait_busy(1'b1);
		check_request("type I request", {fdc_cpu_pkg::REQ_NOP, op}, cpu_request);
		wait_busy(1'b0);
		case (op)
			4'h0: begin
				m_head = 8'd0;
				m_track = 8'd0;
			end
			4'h1: m_head = m_data;
			default: begin
				// step-in moves up a track
				if (op == 4'h4 || op == 4'h5)
					m_dir = 1'b0;
				// step-out moves down a track
				else if (op == 4'h6 || op == 4'h7)
					m_dir = 1'b1;
				// plain step repeats the last direction
				next = m_dir ? m_head - 8'd1 : m_head + 8'd1;
				m_head = next;
				if (op[0])
					m_track = next;
			end
		endcase
		check_byte("type I track_out", m_head, track_out);
		host_read(fdc_host_pkg::REG_TRACK, v);
		check_byte("type I track register", m_track, v);
		st = '0;
		st.head_or_fault = h;
		st.track0_or_lost = (m_head == 8'd0);
		st.index_or_drq = 1'b1;
		check_status("type I status_out", st, status_out);
		host_read(fdc_host_pkg::REG_CMD, v);
		check_status("type I status", st, v);
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		logic [31:0]               r;
		logic [7:0]                v;
		fdc_host_pkg::fdc_status_t st;
		host = '0;
		reset_n = 1'b0;
		errors = 0;
		cycles = 0;
		wr_count = 0;
		stim_seed = 32'h82e1_308b;
		cpu_seed = 32'h82e1_308b;
		fail_read = 1'b0;
		fail_crc = 1'b0;
		m_head = 8'hff;
		m_track = 8'd0;
		m_sector = 8'd0;
		m_data = 8'd0;
		m_dir = 1'b0;
		for (int a = 0; a < 1024; a++) begin
			draw(8, stim_seed, r);
			mem[a] = r[7:0];
		end
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		check_request("reset request", {fdc_cpu_pkg::REQ_ACK, 4'h0}, cpu_request);
		check_byte("reset track_out", 8'hff, track_out);

		// register readback while idle
		for (int i = 0; i < 8; i++) begin
			draw(8, stim_seed, r);
			m_track = r[7:0];
			host_write(fdc_host_pkg::REG_TRACK, m_track);
			draw(8, stim_seed, r);
			m_sector = r[7:0];
			host_write(fdc_host_pkg::REG_SECTOR, m_sector);
			draw(8, stim_seed, r);
			m_side = r[2];
			m_drive = r[0];
			host_write(fdc_host_pkg::REG_CTRL, r[7:0]);
			host_read(fdc_host_pkg::REG_TRACK, v);
			check_byte("track readback", m_track, v);
			host_read(fdc_host_pkg::REG_SECTOR, v);
			check_byte("sector readback", m_sector, v);
			check_byte("sector_out", m_sector, sector_out);
			host_read(fdc_host_pkg::REG_CTRL, v);
			check_byte("control readback", {5'b11111, m_side, 1'b0, m_drive}, v);
		end

		// each type I opcode after a seek to a random track
		for (int op = 0; op < 8; op++) begin
			do_type1(4'h1);
			do_type1(op[3:0]);
		end

		// sector read
		host_write(fdc_host_pkg::REG_CMD, 8'h80);
		wait_busy(1'b1);
		check_request("read request", {fdc_cpu_pkg::REQ_READ, 2'b00, m_drive, m_side},
			cpu_request);
		for (int i = 0; i < SECTOR_SIZE; i++) begin
			wait_drq();
			if (buffer.rd !== 1'b1) begin
				$display("buffer read strobe was low while a read byte was offered");
				errors++;
			end
			draw(2, stim_seed, r);
			repeat (r) @(posedge clk);
			host_read(fdc_host_pkg::REG_DATA, v);
			check_byte("read data", mem[i], v);
		end
		wait_busy(1'b0);
		if (buffer.rd !== 1'b0) begin
			$display("buffer read strobe stayed high after the read ended");
			errors++;
		end

		// sector write
		wr_count = 0;
		host_write(fdc_host_pkg::REG_CMD, 8'ha0);
		wait_busy(1'b1);
		for (int i = 0; i < SECTOR_SIZE; i++) begin
			wait_drq();
			draw(8, stim_seed, r);
			exp_wr[i] = r[7:0];
			host_write(fdc_host_pkg::REG_DATA, r[7:0]);
		end
		wait_request(fdc_cpu_pkg::REQ_WRITE);
		check_request("write request", {fdc_cpu_pkg::REQ_WRITE, 3'b000, m_side}, cpu_request);
		wait_busy(1'b0);
		if (wr_count != SECTOR_SIZE) begin
			$display("write sector stored %0d bytes instead of %0d", wr_count, SECTOR_SIZE);
			errors++;
		end

		// failed read with crc
		fail_read = 1'b1;
		fail_crc = 1'b1;
		host_write(fdc_host_pkg::REG_CMD, 8'h80);
		wait_busy(1'b1);
		wait_busy(1'b0);
		st = '0;
		st.seek_error = 1'b1;
		st.crc_error = 1'b1;
		check_status("failed read status_out", st, status_out);
		host_read(fdc_host_pkg::REG_CMD, v);
		check_status("failed read status", st, v);
		fail_read = 1'b0;
		fail_crc = 1'b0;

		// interrupt in the middle of a write
		wr_count = 0;
		host_write(fdc_host_pkg::REG_CMD, 8'ha0);
		wait_busy(1'b1);
		for (int i = 0; i < 3; i++) begin
			wait_drq();
			draw(8, stim_seed, r);
			exp_wr[i] = r[7:0];
			host_write(fdc_host_pkg::REG_DATA, r[7:0]);
		end
		wait_drq();
		host_write(fdc_host_pkg::REG_CMD, 8'hd0);
		wait_request(fdc_cpu_pkg::REQ_ACK);
		check_request("abort request", {fdc_cpu_pkg::REQ_ACK, 4'h0}, cpu_request);
		wait_busy(1'b0);
		repeat (4) @(posedge clk);
		if (wr_count != 3) begin
			$display("abort left %0d buffer writes instead of 3", wr_count);
			errors++;
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/fdc_host_pkg.sv
common/fdc_cpu_pkg.sv
source/fdc_registers.sv
sequencer/fdc_sequencer.sv
source/fdc_transfer_counter.sv
source/fdc_top.sv
test/tb_clock.sv
test/fdc_tb.sv
